//--- src/cache_pkg.sv
package cache_pkg;

  // ##############################
  // Geometry
  // ##############################

  localparam int NUM_WAYS   = 2;
  localparam int NUM_SETS   = 8;
  localparam int LINE_BYTES = 16;
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_W     = LINE_BYTES * 8;
  localparam int IDX_W      = $clog2(NUM_SETS);
  localparam int OFF_W      = $clog2(LINE_BYTES);
  localparam int TAG_W      = ADDR_W - IDX_W - OFF_W;
  localparam int WORD_BYTES = WORD_W / 8;
  localparam int WSEL_W     = OFF_W - $clog2(WORD_BYTES); // Word index inside a line.

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [IDX_W-1:0]      idx_t;
  typedef logic [WSEL_W-1:0]     wsel_t;
  typedef logic [WORD_BYTES-1:0] wben_t;

  // ##############################
  // Messages
  // ##############################

  typedef enum logic {OP_LOAD, OP_STORE} cache_op_e;
  typedef enum logic {MEM_READ, MEM_WRITE} mem_op_e;

  typedef struct packed {
    cache_op_e op;
    addr_t     addr;
    word_t     data;
    wben_t     wben;
  } cache_req_t;

  typedef struct packed {
    cache_op_e op;
    word_t     data;   // Zero for a store.
  } cache_resp_t;

  typedef struct packed {
    mem_op_e op;
    addr_t   addr;     // Always line aligned.
    line_t   line;
  } mem_req_t;

  typedef struct packed {
    line_t line;
  } mem_resp_t;

  // Commands from the controller to a single way.
  typedef struct packed {
    logic tag_wen;
    logic data_wen;
    logic dirty_set;
    logic dirty_clr;
    logic line_reg_en;
    logic evict_reg_en;
  } way_ctrl_t;

  typedef struct packed {
    logic  hit;
    logic  valid;
    logic  dirty;
    addr_t evict_addr;
    line_t line;
  } way_stat_t;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_WRITE,
    STORE_WRITE,
    RESPOND
  } ctrl_state_e;

endpackage

//--- src/cache_way.sv
`timescale 1ns/1ps

module cache_way import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  addr_t     req_addr,
  input  way_ctrl_t ctrl,
  input  line_t     wr_line,
  output way_stat_t stat,
  output word_t     rd_word
);

  tag_t                cur_tag;
  idx_t                idx;
  wsel_t               word_sel;

  tag_t                tag_mem  [NUM_SETS];
  line_t               data_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;

  addr_t               evict_q;
  line_t               line_q;

  // Address fields.
  assign cur_tag  = req_addr[ADDR_W-1 -: TAG_W];
  assign idx      = req_addr[OFF_W +: IDX_W];
  assign word_sel = req_addr[OFF_W-1 -: WSEL_W];

  // ##############################
  // Arrays
  // ##############################

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tag_mem[idx] <= cur_tag;
    end
    if (ctrl.data_wen) begin
      data_mem[idx] <= wr_line;   // Whole line, the store merge is done upstream.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (ctrl.tag_wen) begin
        valid_q[idx] <= 1'b1;
      end
      if (ctrl.dirty_set) begin
        dirty_q[idx] <= 1'b1;
      end else if (ctrl.dirty_clr) begin
        dirty_q[idx] <= 1'b0;
      end
    end
  end

  // ##############################
  // Registers and status
  // ##############################

  // The victim address is rebuilt from the stored tag, not the request tag.
  always_ff @(posedge clk) begin
    if (ctrl.evict_reg_en) begin
      evict_q <= {tag_mem[idx], idx, {OFF_W{1'b0}}};
    end
    if (ctrl.line_reg_en) begin
      line_q <= data_mem[idx];
    end
  end

  assign stat.hit        = valid_q[idx] && (tag_mem[idx] == cur_tag);
  assign stat.valid      = valid_q[idx];
  assign stat.dirty      = dirty_q[idx];
  assign stat.evict_addr = evict_q;
  assign stat.line       = line_q;

  assign rd_word = line_q[word_sel*WORD_W +: WORD_W]; // Word from the registered line.

  // A store never lands in the same cycle as a refill or a clean.
  a_dirty_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.dirty_set |-> !(ctrl.tag_wen || ctrl.dirty_clr))
    else $error("cache_way: dirty_set together with tag_wen or dirty_clr");

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_val,
  input  cache_req_t               req,
  output logic                     busy,
  output logic                     resp_val,
  output cache_resp_t              resp,
  output logic                     mem_req_val,
  output mem_req_t                 mem_req,
  input  logic                     mem_resp_val,
  input  mem_resp_t                mem_resp,
  output addr_t                    req_addr,
  output way_ctrl_t [NUM_WAYS-1:0] way_ctrl,
  input  way_stat_t [NUM_WAYS-1:0] way_stat,
  input  word_t     [NUM_WAYS-1:0] rd_word,
  output line_t                    wr_line
);

  ctrl_state_e         state_q;
  ctrl_state_e         state_d;
  cache_req_t          req_q;
  line_t               refill_q;
  logic                way_q;
  logic [NUM_SETS-1:0] lru_q;      // Names the way to replace next.

  idx_t                idx;
  wsel_t               word_sel;
  logic [NUM_WAYS-1:0] hit_vec;
  logic                hit_way;
  logic                victim_way;
  logic                sel_way;
  line_t               merged_line;
  way_ctrl_t           cmd;

  assign req_addr = req_q.addr;
  assign idx      = req_q.addr[OFF_W +: IDX_W];
  assign word_sel = req_q.addr[OFF_W-1 -: WSEL_W];
  assign busy     = (state_q != IDLE);

  // ##############################
  // Way selection
  // ##############################

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = way_stat[w].hit;
    end
  end

  assign hit_way = hit_vec[1];

  // Invalid ways are filled first, way 0 before way 1.
  always_comb begin
    if (!way_stat[0].valid) begin
      victim_way = 1'b0;
    end else if (!way_stat[1].valid) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[idx];
    end
  end

  // The choice is made in TAG_CHECK and held in way_q after that.
  assign sel_way = (state_q == TAG_CHECK) ? ((|hit_vec) ? hit_way : victim_way) : way_q;

  always_comb begin
    merged_line = way_stat[way_q].line;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (req_q.wben[b]) begin
        merged_line[word_sel*WORD_W + b*8 +: 8] = req_q.data[b*8 +: 8];
      end
    end
  end

  // ##############################
  // Miss FSM
  // ##############################

  always_comb begin
    state_d     = state_q;
    cmd         = '0;
    wr_line     = refill_q;
    mem_req_val = 1'b0;
    mem_req     = '0;
    resp_val    = 1'b0;
    resp        = '0;

    case (state_q)
      IDLE: begin
        if (req_val) begin
          state_d = TAG_CHECK;
        end
      end
      TAG_CHECK: begin
        cmd.line_reg_en = 1'b1;
        if (|hit_vec) begin
          state_d = (req_q.op == OP_STORE) ? STORE_WRITE : RESPOND;
        end else begin
          cmd.evict_reg_en = 1'b1;
          if (way_stat[victim_way].valid && way_stat[victim_way].dirty) begin
            state_d = EVICT_REQ;
          end else begin
            state_d = REFILL_REQ;
          end
        end
      end
      EVICT_REQ: begin
        mem_req_val  = 1'b1;
        mem_req.op   = MEM_WRITE;
        mem_req.addr = way_stat[way_q].evict_addr;
        mem_req.line = way_stat[way_q].line;
        state_d      = EVICT_WAIT;
      end
      EVICT_WAIT: begin
        if (mem_resp_val) begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        mem_req_val  = 1'b1;
        mem_req.op   = MEM_READ;
        mem_req.addr = {req_q.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        state_d      = REFILL_WAIT;
      end
      REFILL_WAIT: begin
        if (mem_resp_val) begin
          state_d = REFILL_WRITE;
        end
      end
      REFILL_WRITE: begin
        cmd.tag_wen   = 1'b1;
        cmd.data_wen  = 1'b1;
        cmd.dirty_clr = 1'b1;
        state_d       = TAG_CHECK;   // Check again, which now hits.
      end
      STORE_WRITE: begin
        cmd.data_wen  = 1'b1;
        cmd.dirty_set = 1'b1;
        wr_line       = merged_line;
        state_d       = RESPOND;
      end
      RESPOND: begin
        resp_val  = 1'b1;
        resp.op   = req_q.op;
        resp.data = (req_q.op == OP_LOAD) ? rd_word[way_q] : '0;
        state_d   = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Only the selected way sees any command
  always_comb begin
    way_ctrl          = '0;
    way_ctrl[sel_way] = cmd;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      way_q   <= 1'b0;
      lru_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == TAG_CHECK) begin
        way_q <= sel_way;
        if (|hit_vec) begin
          lru_q[idx] <= ~hit_way;   // Point at the way that was not used.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_val) begin
      req_q <= req;
    end
    if (state_q == REFILL_WAIT && mem_resp_val) begin
      refill_q <= mem_resp.line;
    end
  end

  a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == TAG_CHECK) |-> $onehot0(hit_vec))
    else $error("cache_ctrl: more than one way hits");

  a_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
    req_val |-> !busy)
    else $error("cache_ctrl: request while busy");

  a_mem_resp: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp_val |-> (state_q inside {EVICT_WAIT, REFILL_WAIT}))
    else $error("cache_ctrl: memory response without a request");

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_val,
  input  cache_req_t  req,
  output logic        busy,
  output logic        resp_val,
  output cache_resp_t resp,
  output logic        mem_req_val,
  output mem_req_t    mem_req,
  input  logic        mem_resp_val,
  input  mem_resp_t   mem_resp
);

  addr_t                    req_addr;
  line_t                    wr_line;
  way_ctrl_t [NUM_WAYS-1:0] way_ctrl;
  way_stat_t [NUM_WAYS-1:0] way_stat;
  word_t     [NUM_WAYS-1:0] rd_word;

  // ##############################
  // Controller
  // ##############################

  cache_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_val      (req_val),
    .req          (req),
    .busy         (busy),
    .resp_val     (resp_val),
    .resp         (resp),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .req_addr     (req_addr),
    .way_ctrl     (way_ctrl),
    .way_stat     (way_stat),
    .rd_word      (rd_word),
    .wr_line      (wr_line)
  );

  // ##############################
  // Ways
  // ##############################

  // All ways see the same address and write line.
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way i_way (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_addr (req_addr),
      .ctrl     (way_ctrl[w]),
      .wr_line  (wr_line),
      .stat     (way_stat[w]),
      .rd_word  (rd_word[w])
    );
  end

endmodule

//--- verification/tb_mem.sv
`timescale 1ns/1ps

module tb_mem import cache_pkg::*; (
  input  logic      clk,
  input  logic      mem_req_val,
  input  mem_req_t  mem_req,
  output logic      mem_resp_val,
  output mem_resp_t mem_resp
);

  line_t       store [64];   // Backing store for the 1 KB window, one entry per line.
  logic [31:0] lat_state;
  mem_req_t    cur_req;
  int          lat;

  // Latency of 1 to 4 cycles from a private LCG stream.
  function automatic int next_latency();
    lat_state = lat_state * 32'd1664525 + 32'd1013904223;
    return 1 + int'(lat_state[17:16]);
  endfunction

  initial begin
    lat_state    = 32'hf889;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
  end

  always begin
    @(posedge clk);
    if (mem_req_val) begin
      cur_req = mem_req;
      lat     = next_latency();
      if (cur_req.op == MEM_WRITE) begin
        store[cur_req.addr[9:4]] = cur_req.line;
      end
      repeat (lat - 1) @(posedge clk);
      #2;
      mem_resp_val  = 1'b1;
      mem_resp.line = (cur_req.op == MEM_READ) ? store[cur_req.addr[9:4]] : '0;
      @(posedge clk);
      #2;
      mem_resp_val = 1'b0;
      mem_resp     = '0;
    end
  end

endmodule

//--- verification/tb_cache.sv
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

  localparam int    NUM_REQ   = 400;
  localparam int    RESET_CYC = 10;
  localparam int    CYC_LIMIT = NUM_REQ * 30 + RESET_CYC;
  localparam addr_t BASE      = 32'h8000_1000;   // A 1 KB window of 64 lines.

  logic        clk;
  logic        rst_n;
  logic        req_val;
  cache_req_t  req;
  logic        busy;
  logic        resp_val;
  cache_resp_t resp;
  logic        mem_req_val;
  mem_req_t    mem_req;
  logic        mem_resp_val;
  mem_resp_t   mem_resp;

  word_t       model_mem [256];
  tag_t        m_tag     [NUM_WAYS][NUM_SETS];
  logic        m_valid   [NUM_WAYS][NUM_SETS];
  logic        m_dirty   [NUM_WAYS][NUM_SETS];
  logic        m_lru     [NUM_SETS];
  mem_req_t    exp_mem   [$];
  mem_req_t    got_mem   [$];
  logic [31:0] rnd_state;
  int          errors;
  int          num_req;
  int          evictions;
  int          cycles;

  cache_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_val      (req_val),
    .req          (req),
    .busy         (busy),
    .resp_val     (resp_val),
    .resp         (resp),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp)
  );

  tb_mem i_mem (
    .clk          (clk),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ##############################
  // Model
  // ##############################

  function automatic logic [31:0] next_rand();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};   // Depends on every address bit.
  endfunction

  function automatic line_t model_line(addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[k*WORD_W +: WORD_W] = model_mem[a[9:4] * 4 + k];
    end
    return l;
  endfunction

  function automatic cache_req_t rand_req();
    cache_req_t  r;
    logic [31:0] a;
    a      = next_rand();
    r.op   = a[31] ? OP_STORE : OP_LOAD;
    r.addr = BASE | {22'b0, a[25:18], 2'b00};
    r.data = next_rand();
    r.wben = a[15:12];
    return r;
  endfunction

  // Predicts traffic and the response, then updates the model state.
  task automatic predict(input cache_req_t r, output logic hit, output cache_resp_t exp_resp);
    idx_t     s;
    tag_t     t;
    int       w;
    int       v;
    mem_req_t m;
    s   = r.addr[OFF_W +: IDX_W];
    t   = r.addr[ADDR_W-1 -: TAG_W];
    hit = 1'b0;
    w   = 0;
    exp_mem.delete();
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (m_valid[i][s] && m_tag[i][s] == t) begin
        hit = 1'b1;
        w   = i;
      end
    end
    if (!hit) begin
      v = !m_valid[0][s] ? 0 : (!m_valid[1][s] ? 1 : int'(m_lru[s]));
      if (m_valid[v][s] && m_dirty[v][s]) begin
        m.op   = MEM_WRITE;
        m.addr = {m_tag[v][s], s, 4'b0000};
        m.line = model_line(m.addr);
        exp_mem.push_back(m);
        evictions++;
      end
      m.op   = MEM_READ;
      m.addr = r.addr & ~addr_t'(LINE_BYTES - 1);
      m.line = '0;
      exp_mem.push_back(m);
      m_tag[v][s]   = t;
      m_valid[v][s] = 1'b1;
      m_dirty[v][s] = 1'b0;
      w             = v;
    end
    m_lru[s]    = (w == 0);
    exp_resp.op = r.op;
    if (r.op == OP_STORE) begin
      for (int b = 0; b < 4; b++) begin
        if (r.wben[b]) model_mem[r.addr[9:2]][b*8 +: 8] = r.data[b*8 +: 8];
      end
      m_dirty[w][s] = 1'b1;
      exp_resp.data = '0;
    end else begin
      exp_resp.data = model_mem[r.addr[9:2]];
    end
  endtask

  // ##############################
  // Checks
  // ##############################

  task automatic check_resp(input cache_resp_t got, input cache_resp_t exp);
    if (got !== exp) begin
      $display("error %0t: response op %0d data %h, expected op %0d data %h",
               $time, got.op, got.data, exp.op, exp.data);
      errors++;
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("error %0t: memory request op %0d addr %h, expected op %0d addr %h%s",
               $time, got.op, got.addr, exp.op, exp.addr,
               (got.line !== exp.line) ? " (line differs)" : "");
      errors++;
    end
  endtask

  task automatic run_req(input cache_req_t r);
    cache_resp_t exp_resp;
    cache_resp_t got_resp;
    logic        hit;
    int          lat;
    predict(r, hit, exp_resp);
    got_mem.delete();
    req_val = 1'b1;
    req     = r;
    @(posedge clk);
    if (busy || resp_val) begin
      $display("error %0t: request offered while the cache was not idle", $time);
      errors++;
    end
    #2;
    req_val = 1'b0;
    lat     = 0;
    do begin
      @(posedge clk);
      lat++;
      if (!busy) begin
        $display("error %0t: busy low before the response", $time);
        errors++;
      end
      if (mem_req_val) got_mem.push_back(mem_req);
    end while (!resp_val);
    got_resp = resp;
    #2;
    check_resp(got_resp, exp_resp);
    if (got_mem.size() != exp_mem.size()) begin
      $display("error %0t: %0d memory requests, expected %0d",
               $time, got_mem.size(), exp_mem.size());
      errors++;
    end else begin
      foreach (got_mem[i]) check_mem_req(got_mem[i], exp_mem[i]);
    end
    if (hit && lat != ((r.op == OP_STORE) ? 3 : 2)) begin
      $display("error %0t: hit latency %0d cycles", $time, lat);
      errors++;
    end
    num_req++;
  endtask

  // ##############################
  // Timeout
  // ##############################

  initial begin
    cycles = 0;
    while (cycles < CYC_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("run timed out after %0d cycles", cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    cache_req_t r;
    int         err_mark;
    errors    = 0;
    num_req   = 0;
    evictions = 0;
    rnd_state = 32'hf889;
    rst_n     = 1'b0;
    req_val   = 1'b0;
    req       = '0;
    for (int i = 0; i < 256; i++) model_mem[i] = fill_word(BASE + i * 4);
    for (int l = 0; l < 64; l++) i_mem.store[l] = model_line(BASE + l * 16);
    for (int s = 0; s < NUM_SETS; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
      end
    end
    repeat (RESET_CYC) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Two lines per set fill the empty cache.
    err_mark = errors;
    for (int i = 0; i < 2 * NUM_SETS; i++) begin
      r      = rand_req();
      r.op   = OP_LOAD;
      r.addr = BASE + (i / NUM_SETS) * 128 + (i % NUM_SETS) * 16 + r.addr[3:0];
      run_req(r);
      if (got_mem.size() != 1 || got_mem[0].op != MEM_READ) begin
        $display("first access to %h did not issue exactly one refill read", r.addr);
        errors++;
      end
    end
    $display("test cold_fill done: 16 requests, %0d errors", errors - err_mark);

    err_mark = errors;
    for (int i = 0; i < 4 * NUM_SETS; i++) begin
      r      = rand_req();
      r.op   = (i < 2 * NUM_SETS) ? OP_LOAD : OP_STORE;
      r.addr = BASE + ((i / NUM_SETS) % 2) * 128 + (i % NUM_SETS) * 16 + r.addr[3:0];
      run_req(r);
    end
    $display("test hit_timing done: 32 requests, %0d errors", errors - err_mark);

    err_mark = errors;
    for (int i = 0; i < NUM_REQ - 48; i++) begin
      run_req(rand_req());
    end
    $display("test random_mix done: %0d requests, %0d dirty evictions, %0d errors",
             NUM_REQ - 48, evictions, errors - err_mark);

    $display("summary: %0d requests, %0d errors", num_req, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
src/cache_pkg.sv
src/cache_way.sv
src/cache_ctrl.sv
src/cache_top.sv
verification/tb_mem.sv
verification/tb_cache.sv

//--- Bender.yml
package:
  name: cache

sources:
  - src/cache_pkg.sv
  - src/cache_way.sv
  - src/cache_ctrl.sv
  - src/cache_top.sv
  - target: test
    files:
      - verification/tb_mem.sv
      - verification/tb_cache.sv
